/* source/cpu_types_pkg.sv */
`default_nettype none

package cpu_types_pkg;

   ////////////////////////////////////////
   // widths
   typedef logic [31:0] word_t;
   typedef logic [4:0]  regbits_t;
   typedef logic [4:0]  shamt_t;

   ////////////////////////////////////////
   // instruction encodings
   typedef enum logic [5:0] {
      RTYPE = 6'h00,
      BEQ   = 6'h04,
      ADDI  = 6'h08,
      ORI   = 6'h0d,
      LUI   = 6'h0f,
      HALT  = 6'h3f
   } opcode_t;

   typedef enum logic [5:0] {
      SLL = 6'h00,
      ADD = 6'h20,
      SUB = 6'h22,
      AND = 6'h24,
      OR  = 6'h25,
      SLT = 6'h2a
   } funct_t;

   typedef enum logic [2:0] {
      ALU_ADD,   // reset value
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT,
      ALU_SLL,
      ALU_LUI
   } aluop_t;

   typedef enum logic {
      FWD_NONE,
      FWD_WB     // take wb_data
   } fwd_t;

endpackage

`default_nettype wire

/* source/register_file.sv */
`default_nettype none

module register_file #(
   parameter int NUM_REGS = 32
) (
   input  logic                    CLK,
   input  logic                    nRST,
   input  cpu_types_pkg::regbits_t rsel1,
   input  cpu_types_pkg::regbits_t rsel2,
   output cpu_types_pkg::word_t    rdat1,
   output cpu_types_pkg::word_t    rdat2,
   input  logic                    wen,
   input  cpu_types_pkg::regbits_t wsel,
   input  cpu_types_pkg::word_t    wdat
);
   import cpu_types_pkg::*;

   localparam int IDX = $clog2(NUM_REGS);

   word_t regs [NUM_REGS];
   logic  wr_ok;

   assign wr_ok = wen && (wsel != '0) && (32'(wsel) < NUM_REGS);

   // r0 and out-of-range indices read zero, same-cycle write passes through
   function automatic word_t read_port(regbits_t sel);
      if (sel == '0 || 32'(sel) >= NUM_REGS)
         return '0;
      if (wr_ok && sel == wsel)
         return wdat;
      return regs[sel[IDX-1:0]];
   endfunction

   always_comb begin
      rdat1 = read_port(rsel1);
      rdat2 = read_port(rsel2);
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
      end else if (wr_ok) begin
         regs[wsel[IDX-1:0]] <= wdat;
      end
   end

endmodule

`default_nettype wire

/* source/instr_decode.sv */
`default_nettype none

module instr_decode #(
   parameter int NUM_REGS = 32
) (
   input  cpu_types_pkg::word_t    instr,
   input  logic                    instr_valid,
   input  logic                    halted,
   input  cpu_types_pkg::word_t    next_address_in,
   output cpu_types_pkg::regbits_t rsel1,
   output cpu_types_pkg::regbits_t rsel2,
   input  cpu_types_pkg::word_t    rdat1_rf,
   input  cpu_types_pkg::word_t    rdat2_rf,
   output logic                    reg_write,
   output logic                    branch,
   output logic                    alu_src_imm,
   output logic                    reg_dst_rd,
   output cpu_types_pkg::aluop_t   aluop,
   output cpu_types_pkg::word_t    rdat1,
   output cpu_types_pkg::word_t    rdat2,
   output cpu_types_pkg::word_t    sign_ext32,
   output cpu_types_pkg::word_t    immediate,
   output cpu_types_pkg::regbits_t rs,
   output cpu_types_pkg::regbits_t rt,
   output cpu_types_pkg::regbits_t rd,
   output cpu_types_pkg::shamt_t   shamt,
   output cpu_types_pkg::word_t    next_address,
   output logic                    halt
);
   import cpu_types_pkg::*;

   opcode_t op;
   funct_t  fn;
   logic    legal;
   logic    in_range;

   ////////////////////////////////////////
   // field split
   assign op    = opcode_t'(instr[31:26]);
   assign rs    = instr[25:21];
   assign rt    = instr[20:16];
   assign rd    = instr[15:11];
   assign shamt = instr[10:6];
   assign fn    = funct_t'(instr[5:0]);

   assign sign_ext32 = {{16{instr[15]}}, instr[15:0]};
   assign immediate  = {16'h0000, instr[15:0]};   // ori, lui

   assign rsel1        = rs;
   assign rsel2        = rt;
   assign rdat1        = rdat1_rf;
   assign rdat2        = rdat2_rf;
   assign next_address = next_address_in;

   ////////////////////////////////////////
   // control decode
   always_comb begin
      legal       = 1'b1;
      reg_write   = 1'b0;
      branch      = 1'b0;
      alu_src_imm = 1'b0;
      reg_dst_rd  = 1'b0;
      aluop       = ALU_ADD;
      halt        = 1'b0;
      case (op)
         RTYPE: begin
            reg_write  = 1'b1;
            reg_dst_rd = 1'b1;
            case (fn)
               ADD:     aluop = ALU_ADD;
               SUB:     aluop = ALU_SUB;
               AND:     aluop = ALU_AND;
               OR:      aluop = ALU_OR;
               SLT:     aluop = ALU_SLT;
               SLL:     aluop = ALU_SLL;
               default: legal = 1'b0;
            endcase
         end
         ADDI: begin
            reg_write   = 1'b1;
            alu_src_imm = 1'b1;
         end
         ORI: begin
            reg_write   = 1'b1;
            alu_src_imm = 1'b1;
            aluop       = ALU_OR;
         end
         LUI: begin
            reg_write   = 1'b1;
            alu_src_imm = 1'b1;
            aluop       = ALU_LUI;
         end
         BEQ: begin
            branch = 1'b1;
            aluop  = ALU_SUB;
         end
         HALT:    halt  = 1'b1;
         default: legal = 1'b0;
      endcase

      // reduced core has fewer registers
      in_range = (32'(rs) < NUM_REGS) && (32'(rt) < NUM_REGS) &&
                 (!reg_dst_rd || 32'(rd) < NUM_REGS);

      if (!instr_valid || halted || !legal || !in_range) begin
         reg_write   = 1'b0;   // bubble
         branch      = 1'b0;
         alu_src_imm = 1'b0;
         reg_dst_rd  = 1'b0;
         aluop       = ALU_ADD;
         halt        = 1'b0;
      end
   end

endmodule

`default_nettype wire

/* source/pl_id_ex.sv */
`default_nettype none

module pl_id_ex (
   input  logic                    CLK,
   input  logic                    nRST,
   input  logic                    flush,
   input  logic                    wen,
   input  logic                    reg_write_in,
   input  logic                    branch_in,
   input  logic                    alu_src_imm_in,
   input  logic                    reg_dst_rd_in,
   input  cpu_types_pkg::aluop_t   aluop_in,
   input  cpu_types_pkg::word_t    rdat1_in,
   input  cpu_types_pkg::word_t    rdat2_in,
   input  cpu_types_pkg::word_t    sign_ext32_in,
   input  cpu_types_pkg::word_t    immediate_in,
   input  cpu_types_pkg::regbits_t rs_in,
   input  cpu_types_pkg::regbits_t rt_in,
   input  cpu_types_pkg::regbits_t rd_in,
   input  cpu_types_pkg::shamt_t   shamt_in,
   input  cpu_types_pkg::word_t    next_address_in,
   input  logic                    halt_in,
   output logic                    reg_write_out,
   output logic                    branch_out,
   output logic                    alu_src_imm_out,
   output logic                    reg_dst_rd_out,
   output cpu_types_pkg::aluop_t   aluop_out,
   output cpu_types_pkg::word_t    rdat1_out,
   output cpu_types_pkg::word_t    rdat2_out,
   output cpu_types_pkg::word_t    sign_ext32_out,
   output cpu_types_pkg::word_t    immediate_out,
   output cpu_types_pkg::regbits_t rs_out,
   output cpu_types_pkg::regbits_t rt_out,
   output cpu_types_pkg::regbits_t rd_out,
   output cpu_types_pkg::shamt_t   shamt_out,
   output cpu_types_pkg::word_t    next_address_out,
   output logic                    halt_out
);
   import cpu_types_pkg::*;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         reg_write_out    <= 1'b0;
         branch_out       <= 1'b0;
         alu_src_imm_out  <= 1'b0;
         reg_dst_rd_out   <= 1'b0;
         aluop_out        <= ALU_ADD;
         rdat1_out        <= '0;
         rdat2_out        <= '0;
         sign_ext32_out   <= '0;
         immediate_out    <= '0;
         rs_out           <= '0;
         rt_out           <= '0;
         rd_out           <= '0;
         shamt_out        <= '0;
         next_address_out <= '0;
         halt_out         <= 1'b0;
      end else if (flush) begin
         reg_write_out <= 1'b0;   // squash, data left as is
         branch_out    <= 1'b0;
         halt_out      <= 1'b0;
      end else if (wen) begin
         reg_write_out    <= reg_write_in;
         branch_out       <= branch_in;
         alu_src_imm_out  <= alu_src_imm_in;
         reg_dst_rd_out   <= reg_dst_rd_in;
         aluop_out        <= aluop_in;
         rdat1_out        <= rdat1_in;
         rdat2_out        <= rdat2_in;
         sign_ext32_out   <= sign_ext32_in;
         immediate_out    <= immediate_in;
         rs_out           <= rs_in;
         rt_out           <= rt_in;
         rd_out           <= rd_in;
         shamt_out        <= shamt_in;
         next_address_out <= next_address_in;
         halt_out         <= halt_in;
      end
   end

endmodule

`default_nettype wire

/* source/alu_execute.sv */
`default_nettype none

module alu_execute (
   input  logic                    CLK,
   input  logic                    nRST,
   input  logic                    reg_write_out,
   input  logic                    branch_out,
   input  logic                    alu_src_imm_out,
   input  logic                    reg_dst_rd_out,
   input  cpu_types_pkg::aluop_t   aluop_out,
   input  cpu_types_pkg::word_t    rdat1_out,
   input  cpu_types_pkg::word_t    rdat2_out,
   input  cpu_types_pkg::word_t    sign_ext32_out,
   input  cpu_types_pkg::word_t    immediate_out,
   input  cpu_types_pkg::regbits_t rt_out,
   input  cpu_types_pkg::regbits_t rd_out,
   input  cpu_types_pkg::shamt_t   shamt_out,
   input  cpu_types_pkg::word_t    next_address_out,
   input  cpu_types_pkg::fwd_t     fwd_a,
   input  cpu_types_pkg::fwd_t     fwd_b,
   output logic                    branch_taken,
   output cpu_types_pkg::word_t    branch_target,
   output logic                    wb_valid,
   output cpu_types_pkg::regbits_t wb_reg,
   output cpu_types_pkg::word_t    wb_data
);
   import cpu_types_pkg::*;

   word_t opa;
   word_t opb;
   word_t alu_b;
   word_t result;

   assign opa = (fwd_a == FWD_WB) ? wb_data : rdat1_out;
   assign opb = (fwd_b == FWD_WB) ? wb_data : rdat2_out;

   always_comb begin
      if (!alu_src_imm_out)
         alu_b = opb;
      else if (aluop_out == ALU_OR || aluop_out == ALU_LUI)
         alu_b = immediate_out;   // zero extended
      else
         alu_b = sign_ext32_out;
   end

   always_comb begin
      case (aluop_out)
         ALU_ADD: result = opa + alu_b;
         ALU_SUB: result = opa - alu_b;
         ALU_AND: result = opa & alu_b;
         ALU_OR:  result = opa | alu_b;
         ALU_SLT: result = {31'b0, $signed(opa) < $signed(alu_b)};
         ALU_SLL: result = alu_b << shamt_out;
         ALU_LUI: result = alu_b << 16;
         default: result = '0;
      endcase
   end

   assign branch_taken  = branch_out && (opa == opb);
   assign branch_target = next_address_out + {sign_ext32_out[29:0], 2'b00};

   ////////////////////////////////////////
   // write-back register
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST)
         wb_valid <= 1'b0;
      else
         wb_valid <= reg_write_out;
   end

   always_ff @(posedge CLK) begin
      wb_reg  <= reg_dst_rd_out ? rd_out : rt_out;
      wb_data <= result;
   end

endmodule

`default_nettype wire

/* source/hazard_unit.sv */
`default_nettype none

module hazard_unit (
   input  logic                    CLK,
   input  logic                    nRST,
   input  cpu_types_pkg::regbits_t rs,
   input  cpu_types_pkg::regbits_t rt,
   input  logic                    halt_ex,
   input  logic                    wb_valid,
   input  cpu_types_pkg::regbits_t wb_reg,
   input  logic                    branch_taken,
   output cpu_types_pkg::fwd_t     fwd_a,
   output cpu_types_pkg::fwd_t     fwd_b,
   output logic                    flush,
   output logic                    wen,
   output logic                    halted
);
   import cpu_types_pkg::*;

   logic wb_live;

   assign wb_live = wb_valid && (wb_reg != '0);   // r0 never forwarded

   assign fwd_a = (wb_live && wb_reg == rs) ? FWD_WB : FWD_NONE;
   assign fwd_b = (wb_live && wb_reg == rt) ? FWD_WB : FWD_NONE;

   assign flush = branch_taken;   // kill the slot behind a taken beq

   // freeze ID/EX once halt sits in EX
   assign wen = !halted && !halt_ex;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST)
         halted <= 1'b0;
      else if (halt_ex)
         halted <= 1'b1;   // sticky
   end

endmodule

`default_nettype wire

/* source/decode_execute_top.sv */
`default_nettype none

module decode_execute_top #(
   parameter int NUM_REGS = 32
) (
   input  logic                    CLK,
   input  logic                    nRST,
   input  cpu_types_pkg::word_t    instr,
   input  logic                    instr_valid,
   input  cpu_types_pkg::word_t    next_address,
   output logic                    wb_valid,
   output cpu_types_pkg::regbits_t wb_reg,
   output cpu_types_pkg::word_t    wb_data,
   output logic                    branch_taken,
   output cpu_types_pkg::word_t    branch_target,
   output logic                    halted
);
   import cpu_types_pkg::*;

   ////////////////////////////////////////
   // decode side of ID/EX
   logic     reg_write_in, branch_in, alu_src_imm_in, reg_dst_rd_in, halt_in;
   aluop_t   aluop_in;
   word_t    rdat1_in, rdat2_in, sign_ext32_in, immediate_in, next_address_in;
   regbits_t rs_in, rt_in, rd_in;
   shamt_t   shamt_in;

   ////////////////////////////////////////
   // execute side of ID/EX
   logic     reg_write_out, branch_out, alu_src_imm_out, reg_dst_rd_out, halt_out;
   aluop_t   aluop_out;
   word_t    rdat1_out, rdat2_out, sign_ext32_out, immediate_out, next_address_out;
   regbits_t rs_out, rt_out, rd_out;
   shamt_t   shamt_out;

   regbits_t rsel1, rsel2;
   word_t    rf_rdat1, rf_rdat2;
   logic     flush, wen;
   fwd_t     fwd_a, fwd_b;

   register_file #(.NUM_REGS(NUM_REGS)) u_rf (
      .CLK   (CLK),
      .nRST  (nRST),
      .rsel1 (rsel1),
      .rsel2 (rsel2),
      .rdat1 (rf_rdat1),
      .rdat2 (rf_rdat2),
      .wen   (wb_valid),   // write at the edge after wb appears
      .wsel  (wb_reg),
      .wdat  (wb_data)
   );

   instr_decode #(.NUM_REGS(NUM_REGS)) u_dec (
      .instr           (instr),
      .instr_valid     (instr_valid),
      .halted          (halted),
      .next_address_in (next_address),
      .rsel1           (rsel1),
      .rsel2           (rsel2),
      .rdat1_rf        (rf_rdat1),
      .rdat2_rf        (rf_rdat2),
      .reg_write       (reg_write_in),
      .branch          (branch_in),
      .alu_src_imm     (alu_src_imm_in),
      .reg_dst_rd      (reg_dst_rd_in),
      .aluop           (aluop_in),
      .rdat1           (rdat1_in),
      .rdat2           (rdat2_in),
      .sign_ext32      (sign_ext32_in),
      .immediate       (immediate_in),
      .rs              (rs_in),
      .rt              (rt_in),
      .rd              (rd_in),
      .shamt           (shamt_in),
      .next_address    (next_address_in),
      .halt            (halt_in)
   );

   pl_id_ex u_idex (.*);

   alu_execute u_ex (.*);

   hazard_unit u_haz (
      .*,
      .rs      (rs_out),
      .rt      (rt_out),
      .halt_ex (halt_out)
   );

endmodule

`default_nettype wire

/* verif/clock_gen.sv */
`default_nettype none

module clock_gen #(
   parameter int PERIOD = 100
) (
   output logic CLK,
   output logic nRST
);

   initial begin
      CLK = 1'b0;
      nRST <= 1'b0;
      repeat (2) @(posedge CLK);
      nRST <= 1'b1;   // release on a rising edge
   end

   always #(PERIOD / 2) CLK = ~CLK;

endmodule

`default_nettype wire

/* verif/decode_execute_asserts.sv */
`default_nettype none

module decode_execute_asserts (
   input logic                    CLK,
   input logic                    nRST,
   input cpu_types_pkg::regbits_t rs,
   input cpu_types_pkg::regbits_t rt,
   input cpu_types_pkg::fwd_t     fwd_a,
   input cpu_types_pkg::fwd_t     fwd_b,
   input logic                    flush,
   input logic                    wb_valid,
   input logic                    halted
);
   import cpu_types_pkg::*;

   int fail_count = 0;   // read by the testbench at the end

   // the slot squashed behind a taken beq reaches write-back two edges later
   flush_kills_next: assert property (@(posedge CLK) disable iff (!nRST)
      flush |-> ##2 !wb_valid)
   else begin
      fail_count++;
      $error("write-back seen from the slot behind a taken branch");
   end

   halted_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      halted |=> halted)
   else begin
      fail_count++;
      $error("halted fell after being set");
   end

   no_fwd_r0_a: assert property (@(posedge CLK) disable iff (!nRST)
      (fwd_a == FWD_WB) |-> (rs != '0))
   else begin
      fail_count++;
      $error("operand a forwarded for register 0");
   end

   no_fwd_r0_b: assert property (@(posedge CLK) disable iff (!nRST)
      (fwd_b == FWD_WB) |-> (rt != '0))
   else begin
      fail_count++;
      $error("operand b forwarded for register 0");
   end

endmodule

`default_nettype wire

/* verif/tb_decode_execute.sv */
`default_nettype none

module tb_decode_execute;
   import cpu_types_pkg::*;

   localparam int PERIOD    = 100;
   localparam int NUM_TESTS = 5;

   logic     CLK;
   logic     nRST;
   word_t    instr;
   logic     instr_valid;
   word_t    next_address;
   logic     wb_valid;
   regbits_t wb_reg;
   word_t    wb_data;
   logic     branch_taken;
   word_t    branch_target;
   logic     halted;

   ////////////////////////////////////////
   // reference model and expectations
   word_t       ref_regs [32];
   logic        squash_next;
   logic        model_halted;
   word_t       pc;
   logic [31:0] rng_state;

   logic     p1_br;   // one step back
   word_t    p1_tgt;
   logic     p1_wb;
   regbits_t p1_reg;
   word_t    p1_data;
   logic     p1_halted;
   logic     p2_wb;   // two steps back
   regbits_t p2_reg;
   word_t    p2_data;
   logic     p2_halted;

   int errors;
   int tests_passed;
   int tests_failed;

   clock_gen #(.PERIOD(PERIOD)) u_clk (
      .CLK  (CLK),
      .nRST (nRST)
   );

   decode_execute_top #(.NUM_REGS(32)) DUT (
      .CLK           (CLK),
      .nRST          (nRST),
      .instr         (instr),
      .instr_valid   (instr_valid),
      .next_address  (next_address),
      .wb_valid      (wb_valid),
      .wb_reg        (wb_reg),
      .wb_data       (wb_data),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .halted        (halted)
   );

   bind hazard_unit decode_execute_asserts u_chk (
      .CLK      (CLK),
      .nRST     (nRST),
      .rs       (rs),
      .rt       (rt),
      .fwd_a    (fwd_a),
      .fwd_b    (fwd_b),
      .flush    (flush),
      .wb_valid (wb_valid),
      .halted   (halted)
   );

   ////////////////////////////////////////
   // helpers
   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic word_t rtype_word(funct_t fn, regbits_t rs, regbits_t rt,
                                        regbits_t rd, shamt_t sh);
      return {RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t itype_word(opcode_t op, regbits_t rs, regbits_t rt,
                                        logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         errors++;
         $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_reg(input string name, input regbits_t exp, input regbits_t act);
      if (act !== exp) begin
         errors++;
         $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   // in-order interpretation of one issued slot
   task automatic model_issue(input word_t ins, input logic v, input word_t na,
                              output logic e_wb, output regbits_t e_reg,
                              output word_t e_data, output logic e_br,
                              output word_t e_tgt);
      logic [5:0] op;
      logic [5:0] fn;
      regbits_t   f_rs;
      regbits_t   f_rt;
      regbits_t   f_rd;
      shamt_t     f_sh;
      word_t      a;
      word_t      b;
      word_t      sx;
      word_t      zx;
      logic       dead;
      op     = ins[31:26];
      fn     = ins[5:0];
      f_rs   = ins[25:21];
      f_rt   = ins[20:16];
      f_rd   = ins[15:11];
      f_sh   = ins[10:6];
      a      = ref_regs[f_rs];
      b      = ref_regs[f_rt];
      sx     = {{16{ins[15]}}, ins[15:0]};
      zx     = {16'h0000, ins[15:0]};
      e_wb   = 1'b0;
      e_reg  = '0;
      e_data = '0;
      e_br   = 1'b0;
      e_tgt  = '0;
      dead   = !v || squash_next || model_halted;   // slot behind taken beq is lost
      squash_next = 1'b0;
      if (!dead) begin
         case (op)
            RTYPE: begin
               e_wb  = 1'b1;
               e_reg = f_rd;
               case (fn)
                  ADD:     e_data = a + b;
                  SUB:     e_data = a - b;
                  AND:     e_data = a & b;
                  OR:      e_data = a | b;
                  SLT:     e_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  SLL:     e_data = b << f_sh;
                  default: e_wb = 1'b0;
               endcase
            end
            ADDI: begin
               e_wb   = 1'b1;
               e_reg  = f_rt;
               e_data = a + sx;
            end
            ORI: begin
               e_wb   = 1'b1;
               e_reg  = f_rt;
               e_data = a | zx;
            end
            LUI: begin
               e_wb   = 1'b1;
               e_reg  = f_rt;
               e_data = {ins[15:0], 16'h0000};
            end
            BEQ: begin
               e_br        = (a == b);
               e_tgt       = na + (sx << 2);
               squash_next = e_br;
            end
            HALT:    model_halted = 1'b1;
            default: ;
         endcase
         if (e_wb && e_reg != '0)
            ref_regs[e_reg] = e_data;   // r0 stays zero
      end
   endtask

   // one issue slot plus checks on the slots one and two edges back
   task automatic step(input word_t ins, input logic v);
      logic     c_wb;
      regbits_t c_reg;
      word_t    c_data;
      logic     c_br;
      word_t    c_tgt;
      word_t    na;
      na = pc + 32'd4;
      model_issue(ins, v, na, c_wb, c_reg, c_data, c_br, c_tgt);
      @(posedge CLK);
      instr        <= ins;
      instr_valid  <= v;
      next_address <= na;
      pc = na;
      @(negedge CLK);
      check_bit("branch_taken", p1_br, branch_taken);
      if (p1_br)
         check_word("branch_target", p1_tgt, branch_target);
      check_bit("wb_valid", p2_wb, wb_valid);
      if (p2_wb) begin
         check_reg("wb_reg", p2_reg, wb_reg);
         check_word("wb_data", p2_data, wb_data);
      end
      check_bit("halted", p2_halted, halted);
      p2_wb     = p1_wb;
      p2_reg    = p1_reg;
      p2_data   = p1_data;
      p2_halted = p1_halted;
      p1_wb     = c_wb;
      p1_reg    = c_reg;
      p1_data   = c_data;
      p1_halted = model_halted;
      p1_br     = c_br;
      p1_tgt    = c_tgt;
   endtask

   task automatic drain();
      repeat (2) step('0, 1'b0);
   endtask

   task automatic load_reg(input regbits_t r, input word_t val);
      step(itype_word(LUI, 5'd0, r, val[31:16]), 1'b1);
      step(itype_word(ORI, r, r, val[15:0]), 1'b1);
   endtask

   task automatic report_test(input string name, input int e0);
      if (errors == e0) begin
         tests_passed++;
         $display("test %-12s ok", name);
      end else begin
         tests_failed++;
         $display("test %-12s %0d errors", name, errors - e0);
      end
   endtask

   ////////////////////////////////////////
   // directed tests
   task automatic test_reset();
      int e0;
      e0 = errors;
      check_bit("wb_valid", 1'b0, wb_valid);
      check_bit("branch_taken", 1'b0, branch_taken);
      check_bit("halted", 1'b0, halted);
      step(rtype_word(ADD, 5'd1, 5'd2, 5'd3, 5'd0), 1'b0);   // not valid
      step('0, 1'b0);
      drain();
      report_test("reset state", e0);
   endtask

   task automatic test_alu();
      int    e0;
      word_t rnd;
      e0 = errors;
      load_reg(5'd1, xorshift32());
      load_reg(5'd2, xorshift32());
      step(rtype_word(ADD, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1);
      step(rtype_word(SUB, 5'd1, 5'd2, 5'd4, 5'd0), 1'b1);
      step(rtype_word(AND, 5'd1, 5'd2, 5'd5, 5'd0), 1'b1);
      step(rtype_word(OR, 5'd1, 5'd2, 5'd6, 5'd0), 1'b1);
      step(rtype_word(SLT, 5'd1, 5'd2, 5'd7, 5'd0), 1'b1);
      step(rtype_word(SLT, 5'd2, 5'd1, 5'd8, 5'd0), 1'b1);
      rnd = xorshift32();
      step(rtype_word(SLL, 5'd0, 5'd1, 5'd9, rnd[10:6]), 1'b1);
      step(itype_word(ADDI, 5'd1, 5'd10, rnd[15:0]), 1'b1);
      step(itype_word(ADDI, 5'd2, 5'd11, 16'hfff0), 1'b1);   // negative immediate
      step(itype_word(ORI, 5'd2, 5'd12, rnd[31:16]), 1'b1);
      step(itype_word(LUI, 5'd0, 5'd13, rnd[23:8]), 1'b1);
      drain();
      report_test("alu ops", e0);
   endtask

   task automatic test_forwarding();
      int e0;
      e0 = errors;
      load_reg(5'd1, xorshift32());
      load_reg(5'd2, xorshift32());
      step(rtype_word(ADD, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1);
      step(rtype_word(SUB, 5'd3, 5'd1, 5'd4, 5'd0), 1'b1);   // distance 1
      step(rtype_word(AND, 5'd3, 5'd4, 5'd5, 5'd0), 1'b1);   // distance 2 and 1
      step(rtype_word(OR, 5'd5, 5'd3, 5'd6, 5'd0), 1'b1);
      step(rtype_word(ADD, 5'd1, 5'd2, 5'd0, 5'd0), 1'b1);   // write r0
      step(rtype_word(ADD, 5'd0, 5'd1, 5'd7, 5'd0), 1'b1);
      step('0, 1'b0);
      step(rtype_word(OR, 5'd0, 5'd0, 5'd8, 5'd0), 1'b1);
      step(itype_word(ADDI, 5'd7, 5'd9, 16'hffff), 1'b1);
      drain();
      report_test("forwarding", e0);
   endtask

   task automatic test_branches();
      int    e0;
      word_t v;
      e0 = errors;
      v = xorshift32();
      load_reg(5'd10, v);
      load_reg(5'd12, ~v);
      load_reg(5'd11, v);
      step(itype_word(BEQ, 5'd10, 5'd11, 16'hfff8), 1'b1);   // taken with r11 forwarded
      step(rtype_word(ADD, 5'd10, 5'd11, 5'd13, 5'd0), 1'b1);   // squashed
      step(itype_word(ADDI, 5'd10, 5'd14, 16'h0001), 1'b1);
      step(itype_word(BEQ, 5'd10, 5'd12, 16'h0010), 1'b1);   // not taken
      step(rtype_word(ADD, 5'd10, 5'd12, 5'd15, 5'd0), 1'b1);
      drain();
      report_test("branches", e0);
   endtask

   task automatic test_halt();
      int e0;
      e0 = errors;
      step(itype_word(ADDI, 5'd0, 5'd16, 16'h0005), 1'b1);
      step(itype_word(HALT, 5'd0, 5'd0, 16'h0000), 1'b1);
      step(itype_word(ADDI, 5'd0, 5'd17, 16'h0007), 1'b1);
      step(rtype_word(ADD, 5'd16, 5'd16, 5'd18, 5'd0), 1'b1);
      step('0, 1'b0);
      drain();
      check_bit("halted", 1'b1, halted);
      report_test("halt", e0);
   endtask

   ////////////////////////////////////////
   // main sequence
   initial begin
      instr        <= '0;
      instr_valid  <= 1'b0;
      next_address <= '0;
      rng_state    = 32'hcb2a7482;
      squash_next  = 1'b0;
      model_halted = 1'b0;
      pc           = '0;
      for (int i = 0; i < 32; i++)
         ref_regs[i] = '0;
      p1_br        = 1'b0;
      p1_tgt       = '0;
      p1_wb        = 1'b0;
      p1_reg       = '0;
      p1_data      = '0;
      p1_halted    = 1'b0;
      p2_wb        = 1'b0;
      p2_reg       = '0;
      p2_data      = '0;
      p2_halted    = 1'b0;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      @(posedge nRST);
      @(negedge CLK);
      test_reset();
      test_alu();
      test_forwarding();
      test_branches();
      test_halt();
      $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
               tests_passed, tests_failed, errors, DUT.u_haz.u_chk.fail_count);
      if (errors == 0 && tests_failed == 0 && DUT.u_haz.u_chk.fail_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(NUM_TESTS * 200 * PERIOD);
      $display("watchdog expired, the tests did not finish in time");
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
source/cpu_types_pkg.sv
source/register_file.sv
source/instr_decode.sv
source/pl_id_ex.sv
source/alu_execute.sv
source/hazard_unit.sv
source/decode_execute_top.sv
verif/clock_gen.sv
verif/decode_execute_asserts.sv
verif/tb_decode_execute.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode/execute testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_decode_execute -f filelist.f; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_decode_execute +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1
